// File: dv/tb_fp_checks.svh
/*
 * Reference model and typed compare tasks for the multiplier testbench.
 * Included inside the testbench module, which must declare error_count first.
 */
`ifndef TB_FP_CHECKS_SVH
`define TB_FP_CHECKS_SVH

// Truncating IEEE single-precision product, written from the rounding and special-value rules
function automatic fp_mul_pkg::fp_word_t model_mul(input fp_mul_pkg::fp_word_t a,
	input fp_mul_pkg::fp_word_t b);
	logic        sign;
	int          ea;
	int          eb;
	int          exp_r;
	logic [22:0] ma;
	logic [22:0] mb;
	logic [22:0] man_r;
	logic [47:0] prod;
	logic        a_zero;
	logic        b_zero;
	logic        a_inf;
	logic        b_inf;
	logic        a_nan;
	logic        b_nan;
	sign = a[31] ^ b[31];
	ea = int'(a[30:23]);
	eb = int'(b[30:23]);
	ma = a[22:0];
	mb = b[22:0];
	// Denormals count as zero
	a_zero = (ea == 0);
	b_zero = (eb == 0);
	a_inf = (ea == 255) && (ma == '0);
	b_inf = (eb == 255) && (mb == '0);
	a_nan = (ea == 255) && (ma != '0);
	b_nan = (eb == 255) && (mb != '0);
	if (a_nan || b_nan || (a_inf && b_zero) || (a_zero && b_inf))
		return 32'h7FC0_0000;
	if (a_inf || b_inf)
		return {sign, 8'hFF, 23'h0};
	if (a_zero || b_zero)
		return {sign, 31'h0};
	prod = 48'({1'b1, ma}) * 48'({1'b1, mb});
	exp_r = ea + eb - `FP_EXP_BIAS;
	// A product of 2.0 or more carries one more power of two
	if (prod[47])
	begin
		man_r = prod[46:24];
		exp_r = exp_r + 1;
	end
	else
		man_r = prod[45:23];
	if (exp_r > 254)
		return {sign, 8'hFF, 23'h0};
	if (exp_r < 1)
		return {sign, 31'h0};
	return {sign, 8'(exp_r), man_r};
endfunction

// Compares one result word
task automatic check_word(input string name, input fp_mul_pkg::fp_word_t expected,
	input fp_mul_pkg::fp_word_t actual);
	if (actual !== expected)
	begin
		error_count++;
		$display("Error in %s: expected %h, actual %h", name, expected, actual);
	end
endtask

// Compares one credit or pulse count
task automatic check_credit(input string name, input fp_mul_pkg::fp_credit_t expected,
	input fp_mul_pkg::fp_credit_t actual);
	if (actual !== expected)
	begin
		error_count++;
		$display("Error in %s: expected %0d, actual %0d", name, expected, actual);
	end
endtask

`endif

// File: dv/tb_fp_multiplier.sv
/*
 * Directed and seeded random tests for the pipelined multiplier.
 * Producer and consumer are modeled with credits; checks sample on the falling edge.
 */
`include "fp_mul_settings.svh"

module tb_fp_multiplier;

	// Rough length of each test in cycles
	// The watchdog limit is sized from their sum
	localparam int LEN_IDLE = 10;
	localparam int LEN_EXACT = 10;
	localparam int LEN_RANDOM = 60;
	localparam int LEN_SPECIAL = 15;
	localparam int LEN_RANGE = 10;
	localparam int LEN_BACKPRESSURE = 40;
	localparam int WATCHDOG_CYCLES = 20 * (LEN_IDLE + LEN_EXACT + LEN_RANDOM + LEN_SPECIAL
		+ LEN_RANGE + LEN_BACKPRESSURE);

	logic                 clk_i;
	logic                 arst_n_i;
	logic                 valid_i;
	fp_mul_pkg::fp_word_t a_i;
	fp_mul_pkg::fp_word_t b_i;
	logic                 out_credit_i;
	logic                 out_valid_o;
	fp_mul_pkg::fp_word_t result_o;
	logic                 in_credit_o;

	int                     error_count;
	string                  test_name;
	fp_mul_pkg::fp_word_t   expected_q[$];
	fp_mul_pkg::fp_credit_t prod_credits;
	int                     pending_credits;
	logic                   hold_credits;
	int                     delivered_count;
	int                     in_credit_count;
	int unsigned            seed_draw;

	`include "tb_fp_checks.svh"

	fp_multiplier i_fp_multiplier
	(
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.valid_i      (valid_i),
		.a_i          (a_i),
		.b_i          (b_i),
		.out_credit_i (out_credit_i),
		.out_valid_o  (out_valid_o),
		.result_o     (result_o),
		.in_credit_o  (in_credit_o)
	);

	initial
	begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	// Output monitor that compares results in order and counts the credit pulses
	initial
	begin
		forever
		begin
			@(negedge clk_i);
			if (out_valid_o === 1'b1)
			begin
				delivered_count++;
				pending_credits++;
				if (expected_q.size() == 0)
				begin
					error_count++;
					$display("Unexpected result %h in %s, no result was pending", result_o,
						test_name);
				end
				else
					check_word(test_name, expected_q.pop_front(), result_o);
			end
			if (in_credit_o === 1'b1)
			begin
				prod_credits++;
				in_credit_count++;
			end
		end
	end

	// Consumer returns one credit per consumed result unless told to hold them
	initial
	begin
		forever
		begin
			@(posedge clk_i);
			#10;
			if (!hold_credits && pending_credits > 0)
			begin
				out_credit_i = 1'b1;
				pending_credits--;
			end
			else
				out_credit_i = 1'b0;
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	// Drives one operation as soon as the producer holds a credit
	task automatic issue_checked(input fp_mul_pkg::fp_word_t a, input fp_mul_pkg::fp_word_t b,
		input fp_mul_pkg::fp_word_t expected);
		@(posedge clk_i);
		#10;
		while (prod_credits == '0)
		begin
			valid_i = 1'b0;
			@(posedge clk_i);
			#10;
		end
		valid_i = 1'b1;
		a_i = a;
		b_i = b;
		prod_credits--;
		expected_q.push_back(expected);
	endtask

	task automatic issue_modeled(input fp_mul_pkg::fp_word_t a, input fp_mul_pkg::fp_word_t b);
		issue_checked(a, b, model_mul(a, b));
	endtask

	task automatic end_burst();
		@(posedge clk_i);
		#10;
		valid_i = 1'b0;
	endtask

	// Waits until every expected result arrived and its credit went back
	task automatic wait_drain(input int limit);
		int cycles;
		cycles = 0;
		while ((expected_q.size() != 0 || pending_credits != 0) && cycles < limit)
		begin
			@(posedge clk_i);
			cycles++;
		end
		if (expected_q.size() != 0)
		begin
			error_count++;
			$display("%0d results never arrived in %s", expected_q.size(), test_name);
			expected_q.delete();
		end
	endtask

	// Normal operand with an exponent that keeps the product in range
	function automatic fp_mul_pkg::fp_word_t random_normal();
		logic [7:0] exp_f;
		exp_f = 8'(64 + $urandom_range(0, 126));
		return {1'($urandom), exp_f, 23'($urandom)};
	endfunction

	task automatic idle_after_reset();
		int valid_start;
		int credit_start;
		test_name = "idle_after_reset";
		valid_start = delivered_count;
		credit_start = in_credit_count;
		repeat (8) @(posedge clk_i);
		check_credit("idle out_valid pulses", '0, 3'(delivered_count - valid_start));
		check_credit("idle in_credit pulses", '0, 3'(in_credit_count - credit_start));
	endtask

	// Leading one lands at bit 46 for 1.5 x 2.0 and -3.0 x 0.25 and at bit 47 for the squares
	task automatic exact_products();
		test_name = "exact_products";
		issue_checked(32'h3FC0_0000, 32'h4000_0000, 32'h4040_0000);
		issue_checked(32'hC040_0000, 32'h3E80_0000, 32'hBF40_0000);
		issue_checked(32'h3FC0_0000, 32'h3FC0_0000, 32'h4010_0000);
		issue_checked(32'h3FE0_0000, 32'h3FE0_0000, 32'h4044_0000);
		end_burst();
		wait_drain(LEN_EXACT * 4);
	endtask

	task automatic random_normals();
		test_name = "random_normals";
		for (int i = 0; i < 40; i++)
			issue_modeled(random_normal(), random_normal());
		end_burst();
		wait_drain(LEN_RANDOM * 4);
	endtask

	task automatic special_values();
		test_name = "special_values";
		issue_checked(32'h7FC0_0000, 32'h3F80_0000, 32'h7FC0_0000);
		issue_checked(32'hFF80_0001, 32'h0000_0000, 32'h7FC0_0000);
		issue_checked(32'h7F80_0000, 32'h0000_0000, 32'h7FC0_0000);
		issue_checked(32'h8000_0000, 32'hFF80_0000, 32'h7FC0_0000);
		issue_checked(32'h7F80_0000, 32'hBF80_0000, 32'hFF80_0000);
		issue_checked(32'h0000_0000, 32'hC000_0000, 32'h8000_0000);
		// Denormals are flushed before the multiply
		issue_checked(32'h0000_0001, 32'h4000_0000, 32'h0000_0000);
		issue_checked(32'h8040_0000, 32'h3F80_0000, 32'h8000_0000);
		end_burst();
		wait_drain(LEN_SPECIAL * 4);
	endtask

	task automatic exponent_range();
		test_name = "exponent_range";
		issue_checked(32'h7F00_0000, 32'h4000_0000, 32'h7F80_0000);
		issue_checked(32'hFF00_0000, 32'h7F00_0000, 32'hFF80_0000);
		issue_checked(32'h0080_0000, 32'h3F00_0000, 32'h0000_0000);
		issue_checked(32'h8080_0000, 32'h0080_0000, 32'h8000_0000);
		// Largest finite value times one stays finite
		issue_checked(32'h7F7F_FFFF, 32'h3F80_0000, 32'h7F7F_FFFF);
		end_burst();
		wait_drain(LEN_RANGE * 4);
	endtask

	task automatic back_pressure();
		int n;
		int delivered_start;
		int pulses_start;
		test_name = "back_pressure";
		n = `FP_QUEUE_DEPTH + `FP_OUT_CREDITS_INIT;
		delivered_start = delivered_count;
		pulses_start = in_credit_count;
		hold_credits = 1'b1;
		for (int i = 0; i < n; i++)
			issue_modeled(random_normal(), random_normal());
		end_burst();
		repeat (12) @(posedge clk_i);
		check_credit("back_pressure results while held", 3'(`FP_OUT_CREDITS_INIT),
			3'(delivered_count - delivered_start));
		check_credit("back_pressure producer credits while held", '0, prod_credits);
		hold_credits = 1'b0;
		wait_drain(LEN_BACKPRESSURE * 4);
		@(posedge clk_i);
		check_credit("back_pressure results delivered", 3'(n),
			3'(delivered_count - delivered_start));
		check_credit("back_pressure in_credit pulses", 3'(n),
			3'(in_credit_count - pulses_start));
		check_credit("back_pressure producer credits after drain", 3'(`FP_QUEUE_DEPTH),
			prod_credits);
	endtask

	initial
	begin
		seed_draw = $urandom(67444);
		error_count = 0;
		test_name = "reset";
		prod_credits = 3'(`FP_QUEUE_DEPTH);
		pending_credits = 0;
		hold_credits = 1'b0;
		delivered_count = 0;
		in_credit_count = 0;
		arst_n_i = 1'b0;
		valid_i = 1'b0;
		a_i = '0;
		b_i = '0;
		out_credit_i = 1'b0;
		repeat (3) @(posedge clk_i);
		#10;
		arst_n_i = 1'b1;

		idle_after_reset();
		exact_products();
		random_normals();
		special_values();
		exponent_range();
		back_pressure();

		$display("Checks done with %0d errors", error_count);
		if (error_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: hw/fp_mul_pkg.sv
/*
 * Shared vector types for the multiplier datapath and its testbench.
 */
`include "fp_mul_settings.svh"

package fp_mul_pkg;

	// Packed IEEE word with sign, exponent and mantissa fields
	typedef logic [`FP_EXP_WIDTH + `FP_MAN_WIDTH:0] fp_word_t;

	// Biased exponent as stored in the word
	typedef logic [`FP_EXP_WIDTH - 1:0] fp_exp_t;

	// Significand including the hidden one
	typedef logic [`FP_MAN_WIDTH:0] fp_sig_t;

	// Full product of two significands
	typedef logic [2 * (`FP_MAN_WIDTH + 1) - 1:0] fp_product_t;

	// Working exponent with two guard bits, signed so that underflow shows as negative
	typedef logic signed [`FP_EXP_WIDTH + 1:0] fp_wide_exp_t;

	// Special-value class of an operand or a result
	typedef enum logic [1:0]
	{
		FP_CLASS_NORMAL,
		FP_CLASS_ZERO,
		FP_CLASS_INF,
		FP_CLASS_NAN
	} fp_class_t;

	// Credit counter, wide enough for the queue depth
	typedef logic [2:0] fp_credit_t;

endpackage

// File: hw/fp_mul_settings.svh
/*
 * Width and depth settings for the single-precision multiplier.
 * The queue depth must match the producer's initial credit count.
 */
`ifndef FP_MUL_SETTINGS_SVH
`define FP_MUL_SETTINGS_SVH

// Biased exponent field of an IEEE single-precision word
`define FP_EXP_WIDTH 8

// Stored mantissa field, without the hidden one
`define FP_MAN_WIDTH 23

// Exponent bias for single precision
`define FP_EXP_BIAS 127

// Entries in the result FIFO
// The producer starts out holding exactly this many credits
`define FP_QUEUE_DEPTH 4

// Credits granted by the consumer when reset is released
`define FP_OUT_CREDITS_INIT 2

`endif

// File: hw/fp_multiplier.sv
/*
 * Pipelined single-precision multiplier, four cycles from valid_i to
 * out_valid_o when the consumer has credits; truncating, no exception flags.
 */

module fp_multiplier
(
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic                 valid_i,
	input  fp_mul_pkg::fp_word_t a_i,
	input  fp_mul_pkg::fp_word_t b_i,
	input  logic                 out_credit_i,
	output logic                 out_valid_o,
	output fp_mul_pkg::fp_word_t result_o,
	output logic                 in_credit_o
);

	// Unpack stage to multiply stage
	logic                     unp_valid;
	logic                     unp_sign;
	fp_mul_pkg::fp_wide_exp_t unp_exp;
	fp_mul_pkg::fp_sig_t      unp_sig_a;
	fp_mul_pkg::fp_sig_t      unp_sig_b;
	fp_mul_pkg::fp_class_t    unp_class;

	// Multiply stage to normalize stage
	logic                     mul_valid;
	logic                     mul_sign;
	fp_mul_pkg::fp_wide_exp_t mul_exp;
	fp_mul_pkg::fp_product_t  mul_product;
	fp_mul_pkg::fp_class_t    mul_class;

	// Normalize stage into the queue
	logic                     norm_valid;
	fp_mul_pkg::fp_word_t     norm_result;

	fp_unpack_classify i_fp_unpack_classify
	(
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.valid_i  (valid_i),
		.a_i      (a_i),
		.b_i      (b_i),
		.valid_o  (unp_valid),
		.sign_o   (unp_sign),
		.exp_o    (unp_exp),
		.sig_a_o  (unp_sig_a),
		.sig_b_o  (unp_sig_b),
		.class_o  (unp_class)
	);

	fp_significand_multiply i_fp_significand_multiply
	(
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.valid_i   (unp_valid),
		.sign_i    (unp_sign),
		.exp_i     (unp_exp),
		.sig_a_i   (unp_sig_a),
		.sig_b_i   (unp_sig_b),
		.class_i   (unp_class),
		.valid_o   (mul_valid),
		.sign_o    (mul_sign),
		.exp_o     (mul_exp),
		.product_o (mul_product),
		.class_o   (mul_class)
	);

	fp_normalize i_fp_normalize
	(
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.valid_i   (mul_valid),
		.product_i (mul_product),
		.exp_i     (mul_exp),
		.sign_i    (mul_sign),
		.class_i   (mul_class),
		.valid_o   (norm_valid),
		.result_o  (norm_result)
	);

	// Stages never stall, the queue absorbs everything in flight
	fp_result_queue i_fp_result_queue
	(
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.wr_valid_i   (norm_valid),
		.wr_data_i    (norm_result),
		.out_credit_i (out_credit_i),
		.out_valid_o  (out_valid_o),
		.result_o     (result_o),
		.in_credit_o  (in_credit_o)
	);

endmodule

// File: hw/fp_normalize.sv
/*
 * Third stage. Rounding is truncation; out-of-range exponents saturate to
 * signed infinity or flush to signed zero, and every NaN becomes 7FC00000.
 */
`include "fp_mul_settings.svh"

module fp_normalize
(
	input  logic                     clk_i,
	input  logic                     arst_n_i,
	input  logic                     valid_i,
	input  fp_mul_pkg::fp_product_t  product_i,
	input  fp_mul_pkg::fp_wide_exp_t exp_i,
	input  logic                     sign_i,
	input  fp_mul_pkg::fp_class_t    class_i,
	output logic                     valid_o,
	output fp_mul_pkg::fp_word_t     result_o
);

	localparam int PROD_WIDTH = $bits(fp_mul_pkg::fp_product_t);
	localparam int IDX_WIDTH  = $clog2(PROD_WIDTH);

	localparam fp_mul_pkg::fp_word_t     CANONICAL_NAN = 32'h7FC0_0000;
	localparam fp_mul_pkg::fp_wide_exp_t EXP_MAX = fp_mul_pkg::fp_wide_exp_t'((1 << `FP_EXP_WIDTH) - 2);
	localparam fp_mul_pkg::fp_wide_exp_t EXP_MIN = fp_mul_pkg::fp_wide_exp_t'(1);

	logic [IDX_WIDTH-1:0]     highest_bit;
	logic [IDX_WIDTH-1:0]     shift_amount;
	fp_mul_pkg::fp_product_t  shifted;
	logic [`FP_MAN_WIDTH-1:0] mantissa;
	fp_mul_pkg::fp_wide_exp_t exp_adj;
	fp_mul_pkg::fp_word_t     packed_word;

	// Priority encoder, the last match while scanning upward is the highest set bit
	always_comb
	begin
		highest_bit = '0;
		for (int i = 0; i < PROD_WIDTH; i++)
		begin
			if (product_i[i])
				highest_bit = IDX_WIDTH'(i);
		end
	end

	// Distance of the leading one from the top of the product
	assign shift_amount = IDX_WIDTH'(PROD_WIDTH - 1) - highest_bit;

	// Moves the leading one up to bit 47, the bits below it form the mantissa
	assign shifted = product_i << shift_amount;

	// Only the top 23 bits under the hidden one are kept, the rest is dropped
	assign mantissa = shifted[PROD_WIDTH - 2 -: `FP_MAN_WIDTH];

	// Exponent came in assuming the one sits at bit 47
	assign exp_adj = exp_i - fp_mul_pkg::fp_wide_exp_t'(shift_amount);

	// Class takes priority over range checks
	always_comb
	begin
		if (class_i == fp_mul_pkg::FP_CLASS_NAN)
			packed_word = CANONICAL_NAN;
		else if (class_i == fp_mul_pkg::FP_CLASS_INF)
			packed_word = {sign_i, {`FP_EXP_WIDTH{1'b1}}, {`FP_MAN_WIDTH{1'b0}}};
		else if (class_i == fp_mul_pkg::FP_CLASS_ZERO)
			packed_word = {sign_i, {(`FP_EXP_WIDTH + `FP_MAN_WIDTH){1'b0}}};
		else if (exp_adj > EXP_MAX)
			// overflow saturates to infinity
			packed_word = {sign_i, {`FP_EXP_WIDTH{1'b1}}, {`FP_MAN_WIDTH{1'b0}}};
		else if (exp_adj < EXP_MIN)
			// underflow, denormal results are not produced
			packed_word = {sign_i, {(`FP_EXP_WIDTH + `FP_MAN_WIDTH){1'b0}}};
		else
			packed_word = {sign_i, fp_mul_pkg::fp_exp_t'(exp_adj), mantissa};
	end

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			valid_o <= 1'b0;
		else
			valid_o <= valid_i;
	end

	always_ff @(posedge clk_i)
	begin
		result_o <= packed_word;
	end

endmodule

// File: hw/fp_result_queue.sv
/*
 * Result FIFO with credit flow control on both sides. Writes must never find
 * it full; the producer's credits, one per entry, are what guarantee that.
 */
`include "fp_mul_settings.svh"

module fp_result_queue
#(
	parameter int DEPTH = `FP_QUEUE_DEPTH
)
(
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic                 wr_valid_i,
	input  fp_mul_pkg::fp_word_t wr_data_i,
	input  logic                 out_credit_i,
	output logic                 out_valid_o,
	output fp_mul_pkg::fp_word_t result_o,
	output logic                 in_credit_o
);

	localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_WIDTH = $clog2(DEPTH + 1);

	fp_mul_pkg::fp_word_t   mem [DEPTH];
	logic [PTR_WIDTH-1:0]   wr_ptr;
	logic [PTR_WIDTH-1:0]   rd_ptr;
	logic [CNT_WIDTH-1:0]   count;
	fp_mul_pkg::fp_credit_t credits;
	logic                   pop;

	// Wraps explicitly so that a depth which is not a power of two also works
	function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
		if (ptr == PTR_WIDTH'(DEPTH - 1))
			return '0;
		else
			return ptr + 1'b1;
	endfunction

	// An entry leaves as soon as one is stored and the consumer has a credit left
	assign pop = (count != '0) && (credits != '0);

	// Head entry and handshake come straight from registered state
	assign out_valid_o = pop;
	assign result_o    = mem[rd_ptr];

	// Each departing entry frees a slot, which goes back to the producer as a credit
	assign in_credit_o = pop;

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			credits <= fp_mul_pkg::fp_credit_t'(`FP_OUT_CREDITS_INIT);
		end
		else
		begin
			if (wr_valid_i)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);

			// Simultaneous write and pop leave the fill level unchanged
			case ({wr_valid_i, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase

			// A credit returned in the same cycle as a pop cancels out
			credits <= credits + fp_mul_pkg::fp_credit_t'(out_credit_i)
				- fp_mul_pkg::fp_credit_t'(pop);
		end
	end

	// Storage array
	always_ff @(posedge clk_i)
	begin
		if (wr_valid_i)
			mem[wr_ptr] <= wr_data_i;
	end

endmodule

// File: hw/fp_significand_multiply.sv
/*
 * Second stage. Multiplies two 24-bit significands into the full 48-bit
 * product with no rounding; sign, exponent and class ride along unchanged.
 */

module fp_significand_multiply
(
	input  logic                     clk_i,
	input  logic                     arst_n_i,
	input  logic                     valid_i,
	input  logic                     sign_i,
	input  fp_mul_pkg::fp_wide_exp_t exp_i,
	input  fp_mul_pkg::fp_sig_t      sig_a_i,
	input  fp_mul_pkg::fp_sig_t      sig_b_i,
	input  fp_mul_pkg::fp_class_t    class_i,
	output logic                     valid_o,
	output logic                     sign_o,
	output fp_mul_pkg::fp_wide_exp_t exp_o,
	output fp_mul_pkg::fp_product_t  product_o,
	output fp_mul_pkg::fp_class_t    class_o
);

	fp_mul_pkg::fp_product_t product;

	// Both factors are widened first so the multiply is done at full width
	assign product = fp_mul_pkg::fp_product_t'(sig_a_i) * fp_mul_pkg::fp_product_t'(sig_b_i);

	// Valid bit follows the input by one cycle, there is no stall
	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			valid_o <= 1'b0;
		else
			valid_o <= valid_i;
	end

	// With two normal inputs the product lies in [1, 4)
	// so its leading one lands at bit 46 or bit 47
	always_ff @(posedge clk_i)
	begin
		product_o <= product;
		sign_o    <= sign_i;
		exp_o     <= exp_i;
		class_o   <= class_i;
	end

endmodule

// File: hw/fp_unpack_classify.sv
/*
 * First stage. Denormal operands are treated as zero, and the exponent sum
 * already carries the +1 for a product whose leading one sits at the top bit.
 */
`include "fp_mul_settings.svh"

module fp_unpack_classify
(
	input  logic                     clk_i,
	input  logic                     arst_n_i,
	input  logic                     valid_i,
	input  fp_mul_pkg::fp_word_t     a_i,
	input  fp_mul_pkg::fp_word_t     b_i,
	output logic                     valid_o,
	output logic                     sign_o,
	output fp_mul_pkg::fp_wide_exp_t exp_o,
	output fp_mul_pkg::fp_sig_t      sig_a_o,
	output fp_mul_pkg::fp_sig_t      sig_b_o,
	output fp_mul_pkg::fp_class_t    class_o
);

	localparam int SIGN_BIT = `FP_EXP_WIDTH + `FP_MAN_WIDTH;

	// Removes the bias once and adds one for the top-bit product position
	localparam fp_mul_pkg::fp_wide_exp_t EXP_OFFSET = fp_mul_pkg::fp_wide_exp_t'(1 - `FP_EXP_BIAS);

	fp_mul_pkg::fp_exp_t      exp_a;
	fp_mul_pkg::fp_exp_t      exp_b;
	logic [`FP_MAN_WIDTH-1:0] man_a;
	logic [`FP_MAN_WIDTH-1:0] man_b;
	fp_mul_pkg::fp_class_t    class_a;
	fp_mul_pkg::fp_class_t    class_b;
	fp_mul_pkg::fp_class_t    class_comb;
	fp_mul_pkg::fp_wide_exp_t exp_sum;

	// Zero exponent covers both true zero and denormals, which are flushed
	function automatic fp_mul_pkg::fp_class_t classify(input fp_mul_pkg::fp_exp_t exp_f,
		input logic [`FP_MAN_WIDTH-1:0] man_f);
		if (exp_f == '0)
			return fp_mul_pkg::FP_CLASS_ZERO;
		else if (exp_f == '1)
			return (man_f == '0) ? fp_mul_pkg::FP_CLASS_INF : fp_mul_pkg::FP_CLASS_NAN;
		else
			return fp_mul_pkg::FP_CLASS_NORMAL;
	endfunction

	// Field split
	assign exp_a = a_i[SIGN_BIT - 1 -: `FP_EXP_WIDTH];
	assign exp_b = b_i[SIGN_BIT - 1 -: `FP_EXP_WIDTH];
	assign man_a = a_i[`FP_MAN_WIDTH - 1:0];
	assign man_b = b_i[`FP_MAN_WIDTH - 1:0];

	assign class_a = classify(exp_a, man_a);
	assign class_b = classify(exp_b, man_b);

	// Zero-extend both exponents into the signed working width before adding
	assign exp_sum = fp_mul_pkg::fp_wide_exp_t'({2'b00, exp_a})
		+ fp_mul_pkg::fp_wide_exp_t'({2'b00, exp_b}) + EXP_OFFSET;

	// NaN wins, then infinity, then zero
	// Infinity times zero is invalid and becomes NaN
	always_comb
	begin
		if (class_a == fp_mul_pkg::FP_CLASS_NAN || class_b == fp_mul_pkg::FP_CLASS_NAN)
			class_comb = fp_mul_pkg::FP_CLASS_NAN;
		else if ((class_a == fp_mul_pkg::FP_CLASS_INF && class_b == fp_mul_pkg::FP_CLASS_ZERO)
			|| (class_a == fp_mul_pkg::FP_CLASS_ZERO && class_b == fp_mul_pkg::FP_CLASS_INF))
			class_comb = fp_mul_pkg::FP_CLASS_NAN;
		else if (class_a == fp_mul_pkg::FP_CLASS_INF || class_b == fp_mul_pkg::FP_CLASS_INF)
			class_comb = fp_mul_pkg::FP_CLASS_INF;
		else if (class_a == fp_mul_pkg::FP_CLASS_ZERO || class_b == fp_mul_pkg::FP_CLASS_ZERO)
			class_comb = fp_mul_pkg::FP_CLASS_ZERO;
		else
			class_comb = fp_mul_pkg::FP_CLASS_NORMAL;
	end

	always_ff @(posedge clk_i or negedge arst_n_i)
	begin
		if (!arst_n_i)
			valid_o <= 1'b0;
		else
			valid_o <= valid_i;
	end

	// Stage payload, only meaningful while valid_o is high
	always_ff @(posedge clk_i)
	begin
		sign_o  <= a_i[SIGN_BIT] ^ b_i[SIGN_BIT];
		exp_o   <= exp_sum;
		// Hidden one is present only for nonzero exponents
		sig_a_o <= {exp_a != '0, man_a};
		sig_b_o <= {exp_b != '0, man_b};
		class_o <= class_comb;
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the multiplier testbench with Verilator and runs it.
# Exits nonzero when the build or the run fails or the log reports a failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal \
	--top-module tb_fp_multiplier \
	-Mdir obj_dir \
	-f sources.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_fp_multiplier > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi

exit 0

// File: sources.f
+incdir+hw
+incdir+dv
hw/fp_mul_pkg.sv
hw/fp_unpack_classify.sv
hw/fp_significand_multiply.sv
hw/fp_normalize.sv
hw/fp_result_queue.sv
hw/fp_multiplier.sv
dv/tb_fp_multiplier.sv
